//--- rtl/smc_settings.svh
//----------------------------------------
// SMC strobe stage widths
//----------------------------------------
`ifndef SMC_SETTINGS_SVH
`define SMC_SETTINGS_SVH

// Byte lanes on the external bus
`define SMC_BYTE_LANES 4

// Wait-state counter and store width
`define SMC_WS_WIDTH 8

// Strobe edge delay width
`define SMC_EDGE_WIDTH 2

// One-hot sequencer state code
`define SMC_STATE_WIDTH 5

`endif

//--- rtl/smc_seq_pkg.sv
//----------------------------------------
// Sequencer side types
//----------------------------------------
`include "smc_settings.svh"

package smc_seq_pkg;

   // One-hot sequencer states
   typedef enum logic [`SMC_STATE_WIDTH-1:0]
   {
      IDLE  = 5'b00001, // No access in progress
      LE    = 5'b00010, // Leading edge wait
      RW    = 5'b00100, // Strobe active
      STORE = 5'b01000, // Data store between accesses
      FLOAT = 5'b10000  // Bus turnaround
   } smc_state_e;

   typedef logic [`SMC_WS_WIDTH-1:0]   ws_count_t;   // Wait-state count or store
   typedef logic [`SMC_EDGE_WIDTH-1:0] edge_delay_t; // Strobe edge delay

   // Sequencer state pair
   typedef struct packed
   {
      smc_state_e current_state; // Registered state
      smc_state_e next_state;    // State taken next clock
   } smc_seq_s;

   // Wait-state timing from the sequencer
   typedef struct packed
   {
      edge_delay_t oete_store; // Read strobe trailing edge
      ws_count_t   ws_count;   // Running wait-state count
      ws_count_t   ws_store;   // Programmed wait states
   } smc_timing_s;

endpackage

//--- rtl/smc_bus_pkg.sv
//----------------------------------------
// Memory bus side types
//----------------------------------------
`include "smc_settings.svh"

package smc_bus_pkg;

   // One bit per byte lane, active low
   typedef logic [`SMC_BYTE_LANES-1:0] byte_strobe_t;

   // Access request from the sequencer
   typedef struct packed
   {
      logic         valid_access; // Load values valid
      logic         n_read;       // Read when low
      logic         cs;           // Chip select
      byte_strobe_t n_be;         // Byte enables, unregistered
   } smc_access_s;

   // Cycle record held over single or multiple access
   typedef struct packed
   {
      logic n_r_read; // Held direction
      logic r_cs;     // Held chip select
   } smc_cycle_s;

   // Inactive byte lanes
   localparam byte_strobe_t SMC_NO_LANES = '1;

endpackage

//--- rtl/smc_cycle_tracker.sv
//----------------------------------------
// Access cycle tracker
//----------------------------------------
`timescale 1ns/100ps

module smc_cycle_tracker
(
   input  logic                     sys_clk19,     // System clock
   input  logic                     n_sys_reset19, // Async reset, active low
   input  smc_bus_pkg::smc_access_s access,        // Access request
   input  logic                     smc_done,      // One access completed
   input  logic                     mac_done,      // Last of a multiple access
   input  smc_seq_pkg::smc_state_e  next_state,    // Sequencer next state
   output smc_bus_pkg::smc_cycle_s  cycle,         // Held direction and select
   output logic                     smc_busy       // Controller active
);

   import smc_seq_pkg::*;

   logic smc_mac_done; // Whole multiple access finished

   assign smc_mac_done = smc_done & mac_done;

   //----------------------------------------
   // Direction and chip select hold
   //----------------------------------------
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
      begin
         cycle.n_r_read <= 1'b0;
         cycle.r_cs     <= 1'b0;
      end
      else if (access.valid_access) // New access wins over completion
      begin
         cycle.n_r_read <= access.n_read;
         cycle.r_cs     <= access.cs;
      end
      else if (smc_mac_done)
      begin
         // Turnaround, release select
         cycle.n_r_read <= 1'b0;
         cycle.r_cs     <= 1'b0;
      end
   end

   //----------------------------------------
   // Busy flag
   //----------------------------------------
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
         smc_busy <= 1'b0;
      else
         smc_busy <= (next_state != IDLE); // Active outside IDLE
   end

   // Completion without a new access drops the select
   cs_release_a : assert property (@(posedge sys_clk19) disable iff (!n_sys_reset19)
      (smc_mac_done && !access.valid_access) |=> !cycle.r_cs)
      else $error("r_cs still set after completion");

endmodule

//--- rtl/smc_write_strobe.sv
//----------------------------------------
// Write strobe generator
//----------------------------------------
`timescale 1ns/100ps

module smc_write_strobe
(
   input  logic                      sys_clk19,     // System clock
   input  logic                      n_sys_reset19, // Async reset, active low
   input  smc_bus_pkg::smc_access_s  access,        // Access request
   input  smc_bus_pkg::smc_cycle_s   cycle,         // Held cycle record
   input  smc_seq_pkg::smc_state_e   next_state,    // Sequencer next state
   output smc_bus_pkg::byte_strobe_t n_r_we,        // Byte write enables, active low
   output logic                      n_r_wr,        // Write strobe, active low
   output logic                      smc_n_ext_oe   // Bus driver enable, active low
);

   import smc_seq_pkg::*;
   import smc_bus_pkg::*;

   logic not_store; // Strobes suppressed in STORE
   logic wr_new;    // Write loaded this cycle
   logic wr_held;   // Write continuing from held direction
   logic wr_act;    // Write strobe condition
   logic oe_act;    // Driver enable condition

   assign not_store = (next_state != STORE);
   assign wr_new    = access.valid_access & access.n_read;
   assign wr_held   = ~access.valid_access & cycle.n_r_read;
   assign wr_act    = not_store & (wr_new | wr_held);
   // Held write only drives while still busy
   assign oe_act    = not_store & (wr_new | (wr_held & (next_state != IDLE)));

   //----------------------------------------
   // Byte enables and write strobe
   //----------------------------------------
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
      begin
         n_r_we <= SMC_NO_LANES;
         n_r_wr <= 1'b1;
      end
      else if (wr_act)
      begin
         n_r_we <= access.n_be; // Lanes from this cycle's enables
         n_r_wr <= 1'b0;
      end
      else
      begin
         n_r_we <= SMC_NO_LANES;
         n_r_wr <= 1'b1;
      end
   end

   // Output enable for write data
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
         smc_n_ext_oe <= 1'b1;
      else
         smc_n_ext_oe <= ~oe_act;
   end

   // No lane enabled without the write strobe
   we_idle_a : assert property (@(posedge sys_clk19) disable iff (!n_sys_reset19)
      n_r_wr |-> (n_r_we == SMC_NO_LANES))
      else $error("Byte enable active with n_r_wr high");

endmodule

//--- rtl/smc_read_strobe.sv
//----------------------------------------
// Read strobe generator
//----------------------------------------
`timescale 1ns/100ps

module smc_read_strobe
(
   input  logic                     sys_clk19,     // System clock
   input  logic                     n_sys_reset19, // Async reset, active low
   input  smc_bus_pkg::smc_access_s access,        // Access request
   input  smc_bus_pkg::smc_cycle_s  cycle,         // Held cycle record
   input  smc_seq_pkg::smc_seq_s    seq,           // Current and next state
   input  smc_seq_pkg::smc_timing_s timing,        // Wait-state timing
   output logic                     smc_n_rd       // Read strobe, active low
);

   import smc_seq_pkg::*;

   ws_count_t oete_ext;  // Trailing edge at count width
   logic      in_rw;     // Strobe window next cycle
   logic      from_lead; // Entering RW from LE or STORE
   logic      store_ok;  // Trailing edge met by the store
   logic      count_ok;  // Trailing edge met by the count

   //----------------------------------------
   // Trailing edge checks
   //----------------------------------------
   assign oete_ext  = ws_count_t'(timing.oete_store); // Zero extend
   assign in_rw     = (seq.next_state == RW);
   assign from_lead = (seq.current_state == LE) | (seq.current_state == STORE);

   // Zero store means no wait states, strobe straight through
   assign store_ok  = (timing.ws_store >= oete_ext) | (timing.ws_store == '0);
   assign count_ok  = (timing.ws_count > oete_ext) | (timing.ws_count == '0);

   //----------------------------------------
   // Read strobe register
   //----------------------------------------
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
         smc_n_rd <= 1'b1;
      else if (!in_rw)
         smc_n_rd <= 1'b1; // Outside the strobe window
      else if (access.valid_access)
         smc_n_rd <= access.n_read; // Fresh access sets direction
      else if (from_lead)
      begin
         if (store_ok)
            smc_n_rd <= cycle.n_r_read;
         else
            smc_n_rd <= 1'b1;
      end
      else
      begin
         // Mid access from RW or FLOAT
         if (count_ok)
            smc_n_rd <= cycle.n_r_read;
         else
            smc_n_rd <= 1'b1;
      end
   end

   // Strobe released whenever the sequencer leaves RW
   rd_release_a : assert property (@(posedge sys_clk19) disable iff (!n_sys_reset19)
      !in_rw |=> smc_n_rd)
      else $error("smc_n_rd low outside RW");

endmodule

//--- rtl/smc_strobe_top.sv
//----------------------------------------
// SMC strobe stage top
//----------------------------------------
`timescale 1ns/100ps

module smc_strobe_top
(
   input  logic                      sys_clk19,     // System clock
   input  logic                      n_sys_reset19, // Async reset, active low
   input  smc_bus_pkg::smc_access_s  access,        // Access request
   input  smc_seq_pkg::smc_seq_s     seq,           // Sequencer states
   input  smc_seq_pkg::smc_timing_s  timing,        // Wait-state timing
   input  logic                      smc_done,      // One access completed
   input  logic                      mac_done,      // Multiple access completed
   output logic                      smc_n_rd,      // Read strobe, active low
   output logic                      smc_n_ext_oe,  // Bus driver enable, active low
   output logic                      smc_busy,      // Controller active
   output smc_bus_pkg::smc_cycle_s   cycle,         // Held cycle record
   output smc_bus_pkg::byte_strobe_t n_r_we,        // Byte write enables
   output logic                      n_r_wr         // Write strobe, active low
);

   // First stage, holds the access
   smc_cycle_tracker smc_cycle_tracker_i
   (
      .sys_clk19     (sys_clk19),
      .n_sys_reset19 (n_sys_reset19),
      .access        (access),
      .smc_done      (smc_done),
      .mac_done      (mac_done),
      .next_state    (seq.next_state),
      .cycle         (cycle),
      .smc_busy      (smc_busy)
   );

   // Second stage, strobes from the held record
   smc_write_strobe smc_write_strobe_i
   (
      .sys_clk19     (sys_clk19),
      .n_sys_reset19 (n_sys_reset19),
      .access        (access),
      .cycle         (cycle),
      .next_state    (seq.next_state),
      .n_r_we        (n_r_we),
      .n_r_wr        (n_r_wr),
      .smc_n_ext_oe  (smc_n_ext_oe)
   );

   smc_read_strobe smc_read_strobe_i
   (
      .sys_clk19     (sys_clk19),
      .n_sys_reset19 (n_sys_reset19),
      .access        (access),
      .cycle         (cycle),
      .seq           (seq),
      .timing        (timing),
      .smc_n_rd      (smc_n_rd)
   );

endmodule

//--- tb/smc_strobe_tb.sv
//----------------------------------------
// SMC strobe stage testbench
//----------------------------------------
`timescale 1ns/100ps

module smc_strobe_tb;

   import smc_seq_pkg::*;
   import smc_bus_pkg::*;

   // Random runs per test
   localparam int WRITE_RUNS = 12;
   localparam int READ_RUNS  = 10;
   localparam int HELD_RUNS  = 40;

   // Cycles per test including two settle cycles
   localparam int RESET_LEN     = 5;
   localparam int CYCLE_LEN     = 11;
   localparam int WRITE_LEN     = WRITE_RUNS + 6;
   localparam int READ_NEW_LEN  = READ_RUNS + 2;
   localparam int READ_HELD_LEN = 2 * HELD_RUNS + 2;
   localparam int TIMEOUT_CYCLES =
      2 * (RESET_LEN + CYCLE_LEN + WRITE_LEN + READ_NEW_LEN + READ_HELD_LEN);

   logic         sys_clk19;
   logic         n_sys_reset19;
   smc_access_s  access;
   smc_seq_s     seq;
   smc_timing_s  timing;
   logic         smc_done;
   logic         mac_done;
   logic         smc_n_rd;
   logic         smc_n_ext_oe;
   logic         smc_busy;
   smc_cycle_s   cycle;
   byte_strobe_t n_r_we;
   logic         n_r_wr;

   // Reference model registers
   smc_cycle_s   exp_cycle; // Testbench copy of the held record
   logic         exp_busy;
   byte_strobe_t exp_we;
   logic         exp_wr;
   logic         exp_oe;
   logic         exp_rd;

   logic        armed = 1'b0;  // Checks start after the first edge
   int          error_count = 0;
   int          tests_run = 0;
   int          cycle_count = 0;
   logic [31:0] lcg_state = 32'd70;

   smc_strobe_top smc_strobe_top_i
   (
      .sys_clk19     (sys_clk19),
      .n_sys_reset19 (n_sys_reset19),
      .access        (access),
      .seq           (seq),
      .timing        (timing),
      .smc_done      (smc_done),
      .mac_done      (mac_done),
      .smc_n_rd      (smc_n_rd),
      .smc_n_ext_oe  (smc_n_ext_oe),
      .smc_busy      (smc_busy),
      .cycle         (cycle),
      .n_r_we        (n_r_we),
      .n_r_wr        (n_r_wr)
   );

   initial
   begin
      sys_clk19 = 1'b0;
      forever #4 sys_clk19 = ~sys_clk19; // 8 ns period
   end

   //----------------------------------------
   // Helpers
   //----------------------------------------
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic smc_access_s make_access(logic valid, logic n_read, logic cs,
                                               byte_strobe_t n_be);
      smc_access_s acc;
      acc.valid_access = valid;
      acc.n_read       = n_read;
      acc.cs           = cs;
      acc.n_be         = n_be;
      return acc;
   endfunction

   // Order IDLE, LE, RW, STORE, FLOAT
   function automatic smc_state_e pick_state(int n);
      case (n % 5)
         0:       return IDLE;
         1:       return LE;
         2:       return RW;
         3:       return STORE;
         default: return FLOAT;
      endcase
   endfunction

   // Mostly small counts so both edge outcomes occur
   function automatic smc_timing_s rand_timing();
      smc_timing_s tm;
      logic [31:0] r;
      r = lcg_next();
      tm.oete_store = r[17:16];
      tm.ws_store   = r[31] ? r[27:20] : {5'b0, r[20:18]};
      r = lcg_next();
      tm.ws_count   = r[31] ? r[27:20] : {5'b0, r[18:16]};
      return tm;
   endfunction

   // Write direction from the new access or the held record
   function automatic logic write_on(smc_access_s acc, smc_cycle_s held, smc_state_e ns);
      logic dir;
      dir = acc.valid_access ? acc.n_read : held.n_r_read;
      return (ns != STORE) && dir;
   endfunction

   function automatic logic drive_on(smc_access_s acc, smc_cycle_s held, smc_state_e ns);
      if (ns == STORE)
         return 1'b0;
      if (acc.valid_access)
         return acc.n_read;
      return held.n_r_read && (ns != IDLE); // Held write only while busy
   endfunction

   function automatic logic read_level(smc_access_s acc, smc_cycle_s held, smc_seq_s sq,
                                       smc_timing_s tm);
      ws_count_t edge_w;
      edge_w = {6'b0, tm.oete_store};
      if (sq.next_state != RW)
         return 1'b1;
      if (acc.valid_access)
         return acc.n_read;
      if (sq.current_state == LE || sq.current_state == STORE)
         return (tm.ws_store >= edge_w || tm.ws_store == 0) ? held.n_r_read : 1'b1;
      return (tm.ws_count > edge_w || tm.ws_count == 0) ? held.n_r_read : 1'b1;
   endfunction

   task automatic report_mismatch(input string name, input logic [7:0] exp,
                                  input logic [7:0] act);
      error_count++;
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
   endtask

   // One cycle of stimulus on the falling edge
   task automatic drive(input smc_access_s acc, input smc_state_e cur, input smc_state_e nxt,
                        input smc_timing_s tm, input logic done, input logic mdone);
      @(negedge sys_clk19);
      access             = acc;
      seq.current_state  = cur;
      seq.next_state     = nxt;
      timing             = tm;
      smc_done           = done;
      mac_done           = mdone;
   endtask

   task automatic end_test(input string name, input int errors_before);
      drive(make_access(1'b0, 1'b0, 1'b0, '1), IDLE, IDLE, '0, 1'b0, 1'b0);
      drive(make_access(1'b0, 1'b0, 1'b0, '1), IDLE, IDLE, '0, 1'b0, 1'b0);
      tests_run++;
      $display("Test %s done, %0d errors", name, error_count - errors_before);
   endtask

   //----------------------------------------
   // Reference model and checks
   //----------------------------------------
   always_ff @(posedge sys_clk19 or negedge n_sys_reset19)
   begin
      if (!n_sys_reset19)
      begin
         exp_cycle <= '0;
         exp_busy  <= 1'b0;
         exp_we    <= '1;
         exp_wr    <= 1'b1;
         exp_oe    <= 1'b1;
         exp_rd    <= 1'b1;
      end
      else
      begin
         if (access.valid_access)
         begin
            exp_cycle.n_r_read <= access.n_read;
            exp_cycle.r_cs     <= access.cs;
         end
         else if (smc_done && mac_done)
            exp_cycle <= '0; // End of multiple access
         exp_busy <= (seq.next_state != IDLE);
         exp_we   <= write_on(access, exp_cycle, seq.next_state) ? access.n_be : '1;
         exp_wr   <= !write_on(access, exp_cycle, seq.next_state);
         exp_oe   <= !drive_on(access, exp_cycle, seq.next_state);
         exp_rd   <= read_level(access, exp_cycle, seq, timing);
      end
   end

   always @(posedge sys_clk19)
   begin
      armed <= 1'b1;
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("Timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Testbench failed");
         $finish;
      end
   end

   cycle_chk_a : assert property (@(posedge sys_clk19) armed |-> (cycle === exp_cycle))
      else report_mismatch("cycle", $sampled(exp_cycle), $sampled(cycle));
   busy_chk_a : assert property (@(posedge sys_clk19) armed |-> (smc_busy === exp_busy))
      else report_mismatch("smc_busy", $sampled(exp_busy), $sampled(smc_busy));
   we_chk_a : assert property (@(posedge sys_clk19) armed |-> (n_r_we === exp_we))
      else report_mismatch("n_r_we", $sampled(exp_we), $sampled(n_r_we));
   wr_chk_a : assert property (@(posedge sys_clk19) armed |-> (n_r_wr === exp_wr))
      else report_mismatch("n_r_wr", $sampled(exp_wr), $sampled(n_r_wr));
   oe_chk_a : assert property (@(posedge sys_clk19) armed |-> (smc_n_ext_oe === exp_oe))
      else report_mismatch("smc_n_ext_oe", $sampled(exp_oe), $sampled(smc_n_ext_oe));
   rd_chk_a : assert property (@(posedge sys_clk19) armed |-> (smc_n_rd === exp_rd))
      else report_mismatch("smc_n_rd", $sampled(exp_rd), $sampled(smc_n_rd));

   //----------------------------------------
   // Stimulus
   //----------------------------------------
   initial
   begin
      int          mark;
      logic [31:0] r;

      n_sys_reset19 = 1'b0;
      access        = '0;
      seq           = {IDLE, IDLE};
      timing        = '0;
      smc_done      = 1'b0;
      mac_done      = 1'b0;

      // Busy write traffic while reset is held
      mark = error_count;
      for (int i = 0; i < 3; i++)
      begin
         r = lcg_next();
         drive(make_access(1'b1, 1'b1, 1'b1, r[19:16]), LE, RW, rand_timing(), 1'b0, 1'b0);
      end
      n_sys_reset19 = 1'b1; // Release on the third falling edge
      end_test("reset", mark);

      // Load, hold and completion of the cycle record
      mark = error_count;
      drive(make_access(1'b1, 1'b0, 1'b1, '1), IDLE, LE, '0, 1'b0, 1'b0);
      repeat (3)
         drive(make_access(1'b0, 1'b1, 1'b0, '1), LE, RW, '0, 1'b0, 1'b0); // Unloaded values
      drive(make_access(1'b1, 1'b1, 1'b1, '0), RW, STORE, '0, 1'b1, 1'b0);
      drive(make_access(1'b0, 1'b1, 1'b0, '0), STORE, RW, '0, 1'b1, 1'b0); // Single done
      drive(make_access(1'b0, 1'b1, 1'b0, '0), RW, IDLE, '0, 1'b1, 1'b1);  // Clears
      drive(make_access(1'b1, 1'b0, 1'b1, '1), IDLE, LE, '0, 1'b1, 1'b1);  // Load wins
      drive(make_access(1'b0, 1'b0, 1'b0, '1), LE, FLOAT, '0, 1'b1, 1'b1);
      end_test("cycle", mark);

      // Writes with random lanes
      mark = error_count;
      for (int i = 0; i < WRITE_RUNS; i++)
      begin
         r = lcg_next();
         drive(make_access(1'b1, 1'b1, 1'b1, r[19:16]), RW, r[20] ? RW : LE, '0,
               1'b0, 1'b0);
      end
      drive(make_access(1'b1, 1'b1, 1'b1, 4'h5), RW, STORE, '0, 1'b0, 1'b0);
      drive(make_access(1'b0, 1'b0, 1'b0, 4'ha), RW, RW, '0, 1'b0, 1'b0);    // Held write
      drive(make_access(1'b0, 1'b0, 1'b0, 4'h3), RW, STORE, '0, 1'b0, 1'b0);
      drive(make_access(1'b0, 1'b0, 1'b0, 4'h6), RW, IDLE, '0, 1'b0, 1'b0);  // OE stays high
      end_test("write", mark);

      // New access straight into RW
      mark = error_count;
      for (int i = 0; i < READ_RUNS; i++)
      begin
         r = lcg_next();
         drive(make_access(1'b1, r[16], r[17], '1), pick_state(int'(r[22:20])), RW,
               rand_timing(), 1'b0, 1'b0);
      end
      end_test("read_new", mark);

      // Held reads against the trailing edge rules
      mark = error_count;
      for (int i = 0; i < HELD_RUNS; i++)
      begin
         r = lcg_next();
         drive(make_access(1'b1, r[16], 1'b1, '1), IDLE, LE, '0, 1'b0, 1'b0);
         drive(make_access(1'b0, 1'b0, 1'b0, '1), pick_state(1 + int'(r[18:17])), RW,
               rand_timing(), 1'b0, 1'b0);
      end
      end_test("read_held", mark);

      $display("Tests run %0d, errors %0d", tests_run, error_count);
      if (error_count == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

//--- sources.f
+incdir+rtl
rtl/smc_seq_pkg.sv
rtl/smc_bus_pkg.sv
rtl/smc_cycle_tracker.sv
rtl/smc_write_strobe.sv
rtl/smc_read_strobe.sv
rtl/smc_strobe_top.sv
tb/smc_strobe_tb.sv

//--- Bender.yml
package:
  name: smc_strobe

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/smc_seq_pkg.sv
      - rtl/smc_bus_pkg.sv
      - rtl/smc_cycle_tracker.sv
      - rtl/smc_write_strobe.sv
      - rtl/smc_read_strobe.sv
      - rtl/smc_strobe_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tb/smc_strobe_tb.sv
